// ==== source/mem_pkg.sv ====
// Memory subsystem package: shared widths, access sizes, depth and request structs
package mem_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    typedef logic [63:0] dword_t;    // One data doubleword
    typedef logic [63:0] addr_t;     // Byte address, only 11:0 decoded
    typedef logic [31:0] inst_t;     // One instruction
    typedef logic [7:0]  byte_en_t;  // One enable per byte lane
    typedef logic [1:0]  size_t;     // Access size code

    // Access size codes
    localparam size_t SIZE_BYTE  = 2'd0;
    localparam size_t SIZE_HALF  = 2'd1;
    localparam size_t SIZE_WORD  = 2'd2;
    localparam size_t SIZE_DWORD = 2'd3;

    // Memory depth in doublewords
    localparam int MEM_WORDS      = 512;
    localparam int MEM_INDEX_BITS = $clog2(MEM_WORDS);  // Address bits 11:3

    typedef logic [MEM_INDEX_BITS-1:0] mem_index_t;

    //////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////

    // One data-port access, load or store
    typedef struct packed {
        addr_t  addr;
        dword_t wdata;      // Store value, right-justified
        size_t  size;
        logic   is_signed;  // Loads only
        logic   load;
        logic   store;
    } data_req_t;

    // One write into the array
    typedef struct packed {
        mem_index_t index;
        byte_en_t   byte_en;
        dword_t     data;   // Already moved into its lanes
    } mem_write_t;

    // Byte offset inside the doubleword, low bits below the size dropped
    function automatic logic [2:0] byte_offset(addr_t addr, size_t size);
        logic [2:0] offset;
        case (size)
            SIZE_BYTE: offset = addr[2:0];
            SIZE_HALF: offset = {addr[2:1], 1'b0};
            SIZE_WORD: offset = {addr[2], 2'b00};
            default:   offset = 3'b000;  // Doubleword always lane 0
        endcase
        return offset;
    endfunction

endpackage

// ==== source/unified_mem.sv ====
// Unified memory: doubleword array with two asynchronous read ports and a byte-lane write
`timescale 1ns/1ps

module unified_mem (
    input  logic                clk,
    input  mem_pkg::mem_write_t wr,           // Write index, lanes, data
    input  mem_pkg::mem_index_t data_index,   // Load port index
    input  mem_pkg::mem_index_t fetch_index,  // Instruction port index
    output mem_pkg::dword_t     data_word,
    output mem_pkg::dword_t     fetch_word
);

    localparam int LANES = $bits(mem_pkg::byte_en_t);  // Bytes per doubleword

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    mem_pkg::dword_t mem [mem_pkg::MEM_WORDS];  // Code and data share it

    // Start from all zero, nothing loaded from file
    initial begin
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    // Each lane written on its own enable
    // Untouched lanes keep old bytes, so partial stores merge
    always @(posedge clk) begin
        for (int lane = 0; lane < LANES; lane++) begin
            if (wr.byte_en[lane]) begin
                mem[wr.index][lane*8 +: 8] <= wr.data[lane*8 +: 8];  // One byte
            end
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Both combinational, a store shows up the cycle after its edge
    assign data_word  = mem[data_index];   // Data side
    assign fetch_word = mem[fetch_index];  // Instruction side

endmodule

// ==== source/store_align.sv ====
// Store alignment: maps a store request to a doubleword index, lane enables and shifted data
`timescale 1ns/1ps

module store_align (
    input  mem_pkg::data_req_t  req,
    output mem_pkg::mem_write_t wr
);

    logic [2:0]         offset;     // Aligned byte offset
    mem_pkg::byte_en_t  lane_mask;  // Enables before placing at offset

    // Offset with sub-size address bits ignored
    assign offset = mem_pkg::byte_offset(req.addr, req.size);

    // Number of lanes from the access size
    always_comb begin
        case (req.size)
            mem_pkg::SIZE_BYTE: lane_mask = 8'h01;  // 1 lane
            mem_pkg::SIZE_HALF: lane_mask = 8'h03;  // 2 lanes
            mem_pkg::SIZE_WORD: lane_mask = 8'h0f;  // 4 lanes
            default:            lane_mask = 8'hff;  // Full doubleword
        endcase
    end

    //////////////////////////////////////////////////
    // Write request
    //////////////////////////////////////////////////

    always_comb begin
        wr.index = req.addr[mem_pkg::MEM_INDEX_BITS+2:3];  // Address bits 11:3

        // No store, no lanes
        if (req.store) begin
            wr.byte_en = lane_mask << offset;
        end else begin
            wr.byte_en = '0;
        end

        // Low bytes of wdata moved up to the target lanes
        // Bytes above the size land in disabled lanes and are dropped
        wr.data = req.wdata << {offset, 3'b000};
    end

endmodule

// ==== source/load_align.sv ====
// Load alignment: extracts the addressed bytes from a doubleword and sign- or zero-extends
`timescale 1ns/1ps

module load_align (
    input  mem_pkg::data_req_t req,
    input  mem_pkg::dword_t    data_word,  // Raw doubleword from memory
    output mem_pkg::dword_t    load_data
);

    logic [2:0]      offset;   // Aligned byte offset
    mem_pkg::dword_t shifted;  // Addressed bytes moved to lane 0
    logic            fill;     // Extension bit

    assign offset  = mem_pkg::byte_offset(req.addr, req.size);
    assign shifted = data_word >> {offset, 3'b000};

    //////////////////////////////////////////////////
    // Extension
    //////////////////////////////////////////////////

    // Top kept bit copied upward on signed loads, zero otherwise
    always_comb begin
        case (req.size)
            mem_pkg::SIZE_BYTE: begin
                fill      = req.is_signed & shifted[7];
                load_data = {{56{fill}}, shifted[7:0]};
            end
            mem_pkg::SIZE_HALF: begin
                fill      = req.is_signed & shifted[15];
                load_data = {{48{fill}}, shifted[15:0]};
            end
            mem_pkg::SIZE_WORD: begin
                fill      = req.is_signed & shifted[31];
                load_data = {{32{fill}}, shifted[31:0]};
            end
            default: begin
                fill      = 1'b0;  // Nothing above 64 bits
                load_data = shifted;  // Offset is 0 here
            end
        endcase
    end

endmodule

// ==== source/fetch_unit.sv ====
// Fetch unit: program counter with step and jump, and instruction half select
`timescale 1ns/1ps

module fetch_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            run,          // Step by 4 each cycle
    input  logic            jump,         // Redirect, beats run
    input  mem_pkg::addr_t  jump_target,
    input  mem_pkg::dword_t fetch_word,   // Doubleword at pc[11:3]
    output mem_pkg::addr_t  pc,
    output mem_pkg::inst_t  inst
);

    localparam mem_pkg::addr_t INST_BYTES = 64'd4;  // One instruction

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (jump) begin
            pc <= {jump_target[63:2], 2'b00};  // Word aligned target
        end else if (run) begin
            pc <= pc + INST_BYTES;
        end
        // Otherwise hold
    end

    //////////////////////////////////////////////////
    // Instruction select
    //////////////////////////////////////////////////

    // Little-endian, lower address in the low half
    assign inst = pc[2] ? fetch_word[63:32] : fetch_word[31:0];

endmodule

// ==== source/mem_subsystem.sv ====
// Memory subsystem top: fetch unit, load and store alignment around the unified memory
`timescale 1ns/1ps

module mem_subsystem (
    input  logic               clk,
    input  logic               reset,
    input  mem_pkg::data_req_t req,          // Data port access
    input  logic               run,
    input  logic               jump,
    input  mem_pkg::addr_t     jump_target,
    output mem_pkg::dword_t    load_data,    // Valid in a load cycle
    output mem_pkg::inst_t     inst,
    output mem_pkg::addr_t     pc
);

    mem_pkg::mem_write_t wr;          // Store path into the array
    mem_pkg::dword_t     data_word;   // Raw data read
    mem_pkg::dword_t     fetch_word;  // Raw instruction read

    //////////////////////////////////////////////////
    // Instruction side
    //////////////////////////////////////////////////

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .jump        (jump),
        .jump_target (jump_target),
        .fetch_word  (fetch_word),
        .pc          (pc),
        .inst        (inst)
    );

    //////////////////////////////////////////////////
    // Data side
    //////////////////////////////////////////////////

    store_align u_store (
        .req (req),
        .wr  (wr)
    );

    load_align u_load (
        .req       (req),
        .data_word (data_word),
        .load_data (load_data)
    );

    // Indexes from address bits 11:3, read regardless of load strobe
    unified_mem u_mem (
        .clk         (clk),
        .wr          (wr),
        .data_index  (req.addr[mem_pkg::MEM_INDEX_BITS+2:3]),
        .fetch_index (pc[mem_pkg::MEM_INDEX_BITS+2:3]),
        .data_word   (data_word),
        .fetch_word  (fetch_word)
    );

endmodule

// ==== bench/mem_subsystem_tb.sv ====
// Memory subsystem testbench with table-driven loads, stores and fetches against a byte model
`timescale 1ns/1ps

module mem_subsystem_tb;

    //////////////////////////////////////////////////
    // Table types
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_STORE,
        OP_LOAD,
        OP_RUN,    // Step pc with run high
        OP_JUMP,   // Jump wins over a high run
        OP_IDLE,   // Holds pc with run and jump low
        OP_RESET
    } op_t;

    typedef struct packed {
        op_t                op;
        mem_pkg::addr_t     addr;   // Access address or jump target
        mem_pkg::size_t     size;
        logic               sgn;    // Signed load
        logic               rnd;    // Store data from the LFSR
        logic               known;  // Load also checked against value
        mem_pkg::dword_t    value;  // Store data, expected load or expected pc
    } entry_t;

    localparam mem_pkg::size_t SZ_B = mem_pkg::SIZE_BYTE;
    localparam mem_pkg::size_t SZ_H = mem_pkg::SIZE_HALF;
    localparam mem_pkg::size_t SZ_W = mem_pkg::SIZE_WORD;
    localparam mem_pkg::size_t SZ_D = mem_pkg::SIZE_DWORD;

    logic               clk;
    logic               reset;
    mem_pkg::data_req_t req;
    logic               run;
    logic               jump;
    mem_pkg::addr_t     jump_target;
    mem_pkg::dword_t    load_data;
    mem_pkg::inst_t     inst;
    mem_pkg::addr_t     pc;

    entry_t      table_q [$];
    string       names_q [$];
    logic [7:0]  model_mem [4096];  // Byte image of the whole memory
    logic [15:0] lfsr;
    int          errors;
    int          checks;

    mem_subsystem dut (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .run         (run),
        .jump        (jump),
        .jump_target (jump_target),
        .load_data   (load_data),
        .inst        (inst),
        .pc          (pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic add_entry(input string name, input op_t op, input mem_pkg::addr_t addr,
                             input mem_pkg::size_t size, input logic sgn, input logic rnd,
                             input logic known, input mem_pkg::dword_t value);
        entry_t e;
        e = '{op: op, addr: addr, size: size, sgn: sgn, rnd: rnd, known: known, value: value};
        table_q.push_back(e);
        names_q.push_back(name);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_dword(output mem_pkg::dword_t value);
        value = '0;
        for (int b = 0; b < 64; b++) begin
            lfsr  = lfsr_next(lfsr);      // One step per bit
            value = {value[62:0], lfsr[0]};
        end
    endtask

    function automatic int size_bytes(input mem_pkg::size_t size);
        return 1 << size;  // 1, 2, 4 or 8
    endfunction

    // Lane rule with low address bits below the size dropped
    task automatic model_store(input mem_pkg::addr_t addr, input mem_pkg::size_t size,
                               input mem_pkg::dword_t data);
        int         n;
        logic [11:0] base;
        n    = size_bytes(size);
        base = addr[11:0] & ~12'(n - 1);
        for (int i = 0; i < n; i++) begin
            model_mem[base + 12'(i)] = data[8*i +: 8];
        end
    endtask

    function automatic mem_pkg::dword_t model_load(input mem_pkg::addr_t addr,
                                                   input mem_pkg::size_t size, input logic sgn);
        int              n;
        logic [11:0]     base;
        mem_pkg::dword_t v;
        n    = size_bytes(size);
        base = addr[11:0] & ~12'(n - 1);
        v    = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model_mem[base + 12'(i)];
        end
        if (sgn && v[8*n-1]) begin
            for (int b = 8*n; b < 64; b++) begin
                v[b] = 1'b1;  // Sign fill
            end
        end
        return v;
    endfunction

    function automatic mem_pkg::inst_t model_inst(input mem_pkg::addr_t addr);
        logic [11:0] a;
        a = {addr[11:2], 2'b00};
        return {model_mem[a + 12'd3], model_mem[a + 12'd2], model_mem[a + 12'd1], model_mem[a]};
    endfunction

    task automatic compare_value(input string name, input mem_pkg::dword_t exp_val,
                                 input mem_pkg::dword_t act);
        checks++;
        if (exp_val !== act) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp_val, act);
        end
    endtask

    task automatic wait_reset_release(output logic timed_out);
        int cycles;
        cycles = 0;
        while (pc !== '0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        timed_out = (pc !== '0);
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic build_table();
        // Doubleword round trip
        add_entry("dw_store_a", OP_STORE, 64'h100, SZ_D, 1'b0, 1'b1, 1'b0, '0);
        add_entry("dw_load_a",  OP_LOAD,  64'h100, SZ_D, 1'b0, 1'b0, 1'b0, '0);
        add_entry("dw_store_b", OP_STORE, 64'h7f8, SZ_D, 1'b0, 1'b1, 1'b0, '0);
        add_entry("dw_load_b",  OP_LOAD,  64'h7f8, SZ_D, 1'b0, 1'b0, 1'b0, '0);
        // Lane merge where upper data bytes get dropped
        add_entry("merge_base", OP_STORE, 64'h200, SZ_D, 1'b0, 1'b0, 1'b0, 64'h1122334455667788);
        add_entry("merge_byte", OP_STORE, 64'h203, SZ_B, 1'b0, 1'b0, 1'b0, 64'hffffffffffffffab);
        add_entry("merge_half", OP_STORE, 64'h206, SZ_H, 1'b0, 1'b0, 1'b0, 64'h555555555555cdef);
        add_entry("merge_load", OP_LOAD,  64'h200, SZ_D, 1'b0, 1'b0, 1'b1, 64'hcdef3344ab667788);
        add_entry("merge_rnd_b", OP_STORE, 64'h201, SZ_B, 1'b0, 1'b1, 1'b0, '0);
        add_entry("merge_rnd_h", OP_STORE, 64'h205, SZ_H, 1'b0, 1'b1, 1'b0, '0);
        add_entry("merge_load2", OP_LOAD,  64'h200, SZ_D, 1'b0, 1'b0, 1'b0, '0);
        // Sign and zero extension at odd addresses
        add_entry("ext_base", OP_STORE, 64'h300, SZ_D, 1'b0, 1'b0, 1'b0, 64'hc7d8e9faa5b69500);
        add_entry("ld_b_s",   OP_LOAD,  64'h301, SZ_B, 1'b1, 1'b0, 1'b1, 64'hffffffffffffff95);
        add_entry("ld_b_u",   OP_LOAD,  64'h301, SZ_B, 1'b0, 1'b0, 1'b1, 64'h95);
        add_entry("ld_h_s",   OP_LOAD,  64'h303, SZ_H, 1'b1, 1'b0, 1'b1, 64'hffffffffffffa5b6);
        add_entry("ld_h_u",   OP_LOAD,  64'h303, SZ_H, 1'b0, 1'b0, 1'b1, 64'ha5b6);
        add_entry("ld_w_s",   OP_LOAD,  64'h307, SZ_W, 1'b1, 1'b0, 1'b1, 64'hffffffffc7d8e9fa);
        add_entry("ld_w_u",   OP_LOAD,  64'h305, SZ_W, 1'b0, 1'b0, 1'b1, 64'hc7d8e9fa);
        add_entry("ld_b_pos", OP_LOAD,  64'h300, SZ_B, 1'b1, 1'b0, 1'b1, 64'h0);
        add_entry("ld_d_off", OP_LOAD,  64'h305, SZ_D, 1'b0, 1'b0, 1'b1, 64'hc7d8e9faa5b69500);
        // Program words then a step through both halves
        add_entry("inst_w0",  OP_STORE, 64'h0, SZ_W, 1'b0, 1'b1, 1'b0, '0);
        add_entry("inst_w4",  OP_STORE, 64'h4, SZ_W, 1'b0, 1'b1, 1'b0, '0);
        add_entry("inst_w8",  OP_STORE, 64'h8, SZ_W, 1'b0, 1'b1, 1'b0, '0);
        add_entry("inst_w12", OP_STORE, 64'hc, SZ_W, 1'b0, 1'b1, 1'b0, '0);
        add_entry("run_0",    OP_RUN,   '0, SZ_D, 1'b0, 1'b0, 1'b0, 64'h0);
        add_entry("run_4",    OP_RUN,   '0, SZ_D, 1'b0, 1'b0, 1'b0, 64'h4);
        add_entry("run_8",    OP_RUN,   '0, SZ_D, 1'b0, 1'b0, 1'b0, 64'h8);
        add_entry("run_12",   OP_RUN,   '0, SZ_D, 1'b0, 1'b0, 1'b0, 64'hc);
        add_entry("hold_16",  OP_IDLE,  '0, SZ_D, 1'b0, 1'b0, 1'b0, 64'h10);
        add_entry("hold_16b", OP_IDLE,  '0, SZ_D, 1'b0, 1'b0, 1'b0, 64'h10);
        // Jumps with target bits 1:0 cleared
        add_entry("jump_108",  OP_JUMP, 64'h10b, SZ_D, 1'b0, 1'b0, 1'b0, 64'h10);
        add_entry("jump_land", OP_IDLE, '0,      SZ_D, 1'b0, 1'b0, 1'b0, 64'h108);
        add_entry("jump_hold", OP_IDLE, '0,      SZ_D, 1'b0, 1'b0, 1'b0, 64'h108);
        add_entry("jump_300",  OP_JUMP, 64'h302, SZ_D, 1'b0, 1'b0, 1'b0, 64'h108);
        add_entry("run_300",   OP_RUN,  '0,      SZ_D, 1'b0, 1'b0, 1'b0, 64'h300);
        add_entry("run_304",   OP_RUN,  '0,      SZ_D, 1'b0, 1'b0, 1'b0, 64'h304);
        add_entry("stop_308",  OP_IDLE, '0,      SZ_D, 1'b0, 1'b0, 1'b0, 64'h308);
        // Reset mid-run keeps memory
        add_entry("mid_reset",   OP_RESET, '0, SZ_D, 1'b0, 1'b0, 1'b0, 64'h308);
        add_entry("after_reset", OP_IDLE,  '0, SZ_D, 1'b0, 1'b0, 1'b0, 64'h0);
        add_entry("after_run",   OP_RUN,   '0, SZ_D, 1'b0, 1'b0, 1'b0, 64'h0);
        add_entry("after_step",  OP_IDLE,  '0, SZ_D, 1'b0, 1'b0, 1'b0, 64'h4);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        entry_t          e;
        mem_pkg::dword_t wdata;
        logic            timed_out;
        reset       = 1'b1;
        req         = '0;
        run         = 1'b0;
        jump        = 1'b0;
        jump_target = '0;
        lfsr        = 16'd54;
        errors      = 0;
        checks      = 0;
        for (int i = 0; i < 4096; i++) begin
            model_mem[i] = 8'h00;  // Matches the zeroed array
        end
        build_table();

        repeat (10) @(posedge clk);
        #2 reset = 1'b0;
        wait_reset_release(timed_out);

        if (timed_out) begin
            errors++;
            $display("pc did not clear after reset");
        end else begin
            for (int k = 0; k < table_q.size(); k++) begin
                e = table_q[k];
                @(posedge clk);
                #2;
                wdata = e.value;
                if (e.op == OP_STORE && e.rnd) begin
                    random_dword(wdata);
                end
                req.addr      = e.addr;
                req.wdata     = wdata;
                req.size      = e.size;
                req.is_signed = e.sgn;
                req.load      = (e.op == OP_LOAD);
                req.store     = (e.op == OP_STORE);
                run           = (e.op == OP_RUN) || (e.op == OP_JUMP);
                jump          = (e.op == OP_JUMP);
                jump_target   = e.addr;
                reset         = (e.op == OP_RESET);
                #17;  // Just before the next edge

                case (e.op)
                    OP_STORE: model_store(e.addr, e.size, wdata);  // Lands at the coming edge
                    OP_LOAD: begin
                        compare_value(names_q[k], model_load(e.addr, e.size, e.sgn), load_data);
                        if (e.known) begin
                            compare_value({names_q[k], " table"}, e.value, load_data);
                        end
                    end
                    default: begin
                        compare_value({names_q[k], " pc"}, e.value, pc);
                        compare_value({names_q[k], " inst"}, {32'h0, model_inst(e.value)},
                                      {32'h0, inst});
                    end
                endcase
            end

            @(posedge clk);
            #2;
            req   = '0;
            run   = 1'b0;
            jump  = 1'b0;
            reset = 1'b0;
        end

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/mem_pkg.sv
source/unified_mem.sv
source/store_align.sv
source/load_align.sv
source/fetch_unit.sv
source/mem_subsystem.sv
bench/mem_subsystem_tb.sv

// ==== Makefile ====
# Verilator simulation of the memory subsystem testbench

OBJ = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f verilog.f --top-module mem_subsystem_tb -Mdir $(OBJ)
	./$(OBJ)/Vmem_subsystem_tb | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
